//--- Bender.yml
package:
  name: cell_switch

sources:
  - include_dirs:
      - hw
    files:
      - hw/switch_pkg.sv
      - hw/ptr_fifo.sv
      - hw/cell_ram.sv
      - hw/voq.sv
      - hw/ingress_stage.sv
      - hw/voq_scheduler.sv
      - hw/crossbar_egress.sv
      - hw/switch_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verification/switch_tb.sv

//--- filelist.f
+incdir+hw
hw/switch_pkg.sv
hw/ptr_fifo.sv
hw/cell_ram.sv
hw/voq.sv
hw/ingress_stage.sv
hw/voq_scheduler.sv
hw/crossbar_egress.sv
hw/switch_top.sv
verification/switch_tb.sv

//--- hw/cell_ram.sv
`timescale 1ns/10ps
`include "switch_config.svh"

module cell_ram (
    input  logic               clk,
    input  logic               wr_en,
    input  switch_pkg::addr_t  wr_addr,
    input  switch_pkg::cell_t  wr_data,
    input  logic               rd_en,
    input  switch_pkg::addr_t  rd_addr,
    output switch_pkg::cell_t  rd_data
);

    switch_pkg::cell_t mem [`VOQ_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read data shows up the cycle after rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

//--- hw/crossbar_egress.sv
`timescale 1ns/10ps
`include "switch_config.svh"

module crossbar_egress import switch_pkg::*; (
    input  logic                             clk,
    input  logic                             arst_n,
    input  port_vec_t                        rd_issued,
    input  cell_t [`PORT_NUB_TOTAL-1:0]      rd_cell,
    output port_vec_t                        out_valid,
    output cell_t [`PORT_NUB_TOTAL-1:0]      out_cell
);

    localparam int N = `PORT_NUB_TOTAL;

    port_vec_t [N-1:0]  hit;
    port_vec_t          nxt_valid;
    cell_t [N-1:0]      nxt_cell;

    // Steer each cell read last cycle to the output named by dst
    always_comb begin
        hit       = '0;
        nxt_valid = '0;
        nxt_cell  = '0;
        for (int o = 0; o < N; o++) begin
            for (int i = 0; i < N; i++) begin
                if (rd_issued[i] && (rd_cell[i].dst == port_t'(o))) begin
                    hit[o][i]    = 1'b1;
                    nxt_valid[o] = 1'b1;
                    nxt_cell[o]  = rd_cell[i];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= '0;
        end else begin
            out_valid <= nxt_valid;
        end
    end

    always_ff @(posedge clk) begin
        for (int o = 0; o < N; o++) begin
            if (nxt_valid[o]) begin
                out_cell[o] <= nxt_cell[o];
            end
        end
    end

    // The matching one cycle earlier must keep outputs apart
    generate
        for (genvar g = 0; g < N; g++) begin : g_check
            a_no_collision: assert property (@(posedge clk) disable iff (!arst_n)
                $onehot0(hit[g]));
        end
    endgenerate

endmodule

//--- hw/ingress_stage.sv
`timescale 1ns/10ps
`include "switch_config.svh"

module ingress_stage import switch_pkg::*; (
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  port_vec_t                            in_valid,
    input  port_cell_t [`PORT_NUB_TOTAL-1:0]     in_cell,
    input  port_vec_t                            full,
    output port_vec_t                            wr_valid,
    output cell_t      [`PORT_NUB_TOTAL-1:0]     wr_cell,
    output port_vec_t                            drop
);

    localparam int N = `PORT_NUB_TOTAL;

    port_vec_t           valid_q;
    cell_t [N-1:0]       cell_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else begin
            valid_q <= in_valid;
        end
    end

    // Each arrival is stamped with the port it came in on
    always_ff @(posedge clk) begin
        for (int i = 0; i < N; i++) begin
            if (in_valid[i]) begin
                cell_q[i].src  <= port_t'(i);
                cell_q[i].dst  <= in_cell[i].dst;
                cell_q[i].data <= in_cell[i].data;
            end
        end
    end

    // No back-pressure upstream, so a full buffer loses the cell
    assign wr_valid = valid_q & ~full;
    assign drop     = valid_q & full;
    assign wr_cell  = cell_q;

endmodule

//--- hw/ptr_fifo.sv
`timescale 1ns/10ps
`include "switch_config.svh"

module ptr_fifo import switch_pkg::*; #(
    parameter bit PRELOAD = 1'b0
) (
    input  logic   clk,
    input  logic   arst_n,
    input  logic   push,
    input  addr_t  push_addr,
    input  logic   pop,
    output addr_t  head,
    output logic   empty,
    output logic   full
);

    localparam int DEPTH = `VOQ_DEPTH;

    addr_t                   mem [DEPTH];
    addr_t                   wr_ptr;
    addr_t                   rd_ptr;
    logic [$clog2(DEPTH):0]  count;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= PRELOAD ? DEPTH[$clog2(DEPTH):0] : '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == addr_t'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == addr_t'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + push - pop;
        end
    end

    generate
        if (PRELOAD) begin : g_preload
            // The free list starts out holding every buffer address
            always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                    for (int i = 0; i < DEPTH; i++) begin
                        mem[i] <= addr_t'(i);
                    end
                end else if (push) begin
                    mem[wr_ptr] <= push_addr;
                end
            end
        end else begin : g_plain
            always_ff @(posedge clk) begin
                if (push) begin
                    mem[wr_ptr] <= push_addr;
                end
            end
        end
    endgenerate

    assign head  = mem[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == DEPTH[$clog2(DEPTH):0]);

    a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n) push |-> !full);
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!arst_n) pop |-> !empty);

endmodule

//--- hw/switch_config.svh
`ifndef SWITCH_CONFIG_SVH
`define SWITCH_CONFIG_SVH

// Number of switch ports, both inputs and outputs
`define PORT_NUB_TOTAL 4

// Width of the payload carried by one cell
`define DATA_WIDTH 16

// Cells held in the shared buffer of each input
`define VOQ_DEPTH 8

`endif

//--- hw/switch_pkg.sv
`include "switch_config.svh"

package switch_pkg;

    typedef logic [$clog2(`PORT_NUB_TOTAL)-1:0] port_t;

    typedef logic [$clog2(`VOQ_DEPTH)-1:0] addr_t;

    // Cell as it arrives at an input
    typedef struct packed {
        port_t                   dst;
        logic [`DATA_WIDTH-1:0]  data;
    } port_cell_t;

    // Cell as stored in a buffer and delivered at an output
    typedef struct packed {
        port_t                   src;
        port_t                   dst;
        logic [`DATA_WIDTH-1:0]  data;
    } cell_t;

    typedef logic [`PORT_NUB_TOTAL-1:0] port_vec_t;

    // Row i holds the non-empty flags of input i, one bit per output
    typedef port_vec_t [`PORT_NUB_TOTAL-1:0] req_mat_t;

endpackage

//--- hw/switch_top.sv
`timescale 1ns/10ps
`include "switch_config.svh"

module switch_top import switch_pkg::*; (
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  port_vec_t                            in_valid,
    input  port_cell_t [`PORT_NUB_TOTAL-1:0]     in_cell,
    output port_vec_t                            out_valid,
    output cell_t      [`PORT_NUB_TOTAL-1:0]     out_cell,
    output port_vec_t                            drop
);

    localparam int N = `PORT_NUB_TOTAL;

    port_vec_t       wr_valid;
    cell_t [N-1:0]   wr_cell;
    port_vec_t       full;
    req_mat_t        req;
    port_vec_t       rd_valid;
    port_t [N-1:0]   rd_sel;
    cell_t [N-1:0]   rd_cell;
    port_vec_t       rd_issued;

    ingress_stage ingress_stage_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_valid (in_valid),
        .in_cell  (in_cell),
        .full     (full),
        .wr_valid (wr_valid),
        .wr_cell  (wr_cell),
        .drop     (drop)
    );

    generate
        for (genvar g = 0; g < N; g++) begin : g_voq
            voq voq_i (
                .clk      (clk),
                .arst_n   (arst_n),
                .wr_valid (wr_valid[g]),
                .wr_cell  (wr_cell[g]),
                .rd_valid (rd_valid[g]),
                .rd_sel   (rd_sel[g]),
                .rd_cell  (rd_cell[g]),
                .nonempty (req[g]),
                .full     (full[g])
            );
        end
    endgenerate

    voq_scheduler voq_scheduler_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .req       (req),
        .rd_valid  (rd_valid),
        .rd_sel    (rd_sel),
        .rd_issued (rd_issued)
    );

    crossbar_egress crossbar_egress_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .rd_issued (rd_issued),
        .rd_cell   (rd_cell),
        .out_valid (out_valid),
        .out_cell  (out_cell)
    );

endmodule

//--- hw/voq.sv
`timescale 1ns/10ps
`include "switch_config.svh"

module voq import switch_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       wr_valid,
    input  cell_t      wr_cell,
    input  logic       rd_valid,
    input  port_t      rd_sel,
    output cell_t      rd_cell,
    output port_vec_t  nonempty,
    output logic       full
);

    localparam int N = `PORT_NUB_TOTAL;

    logic                wr_en;
    logic                rd_en;
    addr_t               free_head;
    logic                free_empty;
    addr_t [N-1:0]       q_head;
    port_vec_t           q_empty;
    port_vec_t           q_push;
    port_vec_t           q_pop;
    addr_t               rd_addr;

    assign wr_en   = wr_valid && !full;
    assign rd_en   = rd_valid;
    assign rd_addr = q_head[rd_sel];

    // The buffer is full once no free address is left
    assign full = free_empty;

    ptr_fifo #(
        .PRELOAD (1'b1)
    ) free_list_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (rd_en),
        .push_addr (rd_addr),
        .pop       (wr_en),
        .head      (free_head),
        .empty     (free_empty),
        .full      ()
    );

    genvar g;
    generate
        for (g = 0; g < N; g++) begin : g_queue
            assign q_push[g] = wr_en && (wr_cell.dst == port_t'(g));
            assign q_pop[g]  = rd_en && (rd_sel == port_t'(g));

            ptr_fifo #(
                .PRELOAD (1'b0)
            ) addr_queue_i (
                .clk       (clk),
                .arst_n    (arst_n),
                .push      (q_push[g]),
                .push_addr (free_head),
                .pop       (q_pop[g]),
                .head      (q_head[g]),
                .empty     (q_empty[g]),
                .full      ()
            );
        end
    endgenerate

    assign nonempty = ~q_empty;

    cell_ram cell_ram_i (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (free_head),
        .wr_data (wr_cell),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_cell)
    );

    // Ingress must have dropped the cell already
    a_no_write_full: assert property (@(posedge clk) disable iff (!arst_n)
        wr_valid |-> !full);

    // The scheduler only grants queues that report cells
    a_no_read_empty: assert property (@(posedge clk) disable iff (!arst_n)
        rd_valid |-> nonempty[rd_sel]);

endmodule

//--- hw/voq_scheduler.sv
`timescale 1ns/10ps
`include "switch_config.svh"

module voq_scheduler import switch_pkg::*; (
    input  logic                             clk,
    input  logic                             arst_n,
    input  req_mat_t                         req,
    output port_vec_t                        rd_valid,
    output port_t [`PORT_NUB_TOTAL-1:0]      rd_sel,
    output port_vec_t                        rd_issued
);

    localparam int N = `PORT_NUB_TOTAL;

    port_t [N-1:0]      rr_ptr;
    port_t [N-1:0]      winner;
    port_vec_t [N-1:0]  out_gnt;
    port_vec_t [N-1:0]  in_gnt;

    // Outputs pick in fixed order, each starting from its own pointer
    always_comb begin
        port_t idx;
        logic  found;

        rd_valid = '0;
        rd_sel   = '0;
        out_gnt  = '0;
        winner   = '0;
        for (int o = 0; o < N; o++) begin
            found = 1'b0;
            for (int k = 0; k < N; k++) begin
                idx = port_t'(rr_ptr[o] + k);
                if (!found && req[idx][o] && !rd_valid[idx]) begin
                    found          = 1'b1;
                    rd_valid[idx]  = 1'b1;
                    rd_sel[idx]    = port_t'(o);
                    out_gnt[o][idx] = 1'b1;
                    winner[o]      = idx;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rr_ptr    <= '0;
            rd_issued <= '0;
        end else begin
            rd_issued <= rd_valid;
            for (int o = 0; o < N; o++) begin
                if (|out_gnt[o]) begin
                    rr_ptr[o] <= winner[o] + 1'b1;
                end
            end
        end
    end

    genvar g;
    generate
        for (g = 0; g < N; g++) begin : g_check
            for (genvar h = 0; h < N; h++) begin : g_transpose
                assign in_gnt[g][h] = out_gnt[h][g];
            end

            a_one_per_output: assert property (@(posedge clk) disable iff (!arst_n)
                $onehot0(out_gnt[g]));
            a_one_per_input: assert property (@(posedge clk) disable iff (!arst_n)
                $onehot0(in_gnt[g]));
        end
    endgenerate

endmodule

//--- verification/switch_tb.sv
`timescale 1ns/10ps
`include "switch_config.svh"

module switch_tb import switch_pkg::*; ();

    localparam int N           = `PORT_NUB_TOTAL;
    localparam int CLK_PERIOD  = 20;
    localparam int N_BURST     = 6;
    localparam int N_PERM      = 5;
    localparam int N_CONT      = 6;
    localparam int OVF_MAX     = 60;
    localparam int RAND_CYCLES = 200;
    localparam int DRAIN_LIMIT = 200;
    localparam int TOTAL_CELLS = 1 + N_BURST + N * N_PERM + N * N_CONT + 2 * (OVF_MAX + 4)
                                 + N * RAND_CYCLES;

    logic                  clk;
    logic                  arst_n;
    port_vec_t             in_valid;
    port_cell_t [N-1:0]    in_cell;
    port_vec_t             out_valid;
    cell_t [N-1:0]         out_cell;
    port_vec_t             drop;

    port_vec_t             sent_valid = '0;
    port_cell_t [N-1:0]    sent_cell;
    cell_t                 exp_q [N*N][$];
    int                    exp_t [N*N][$];
    port_vec_t             chk_valid = '0;
    port_vec_t             exp_found = '0;
    cell_t [N-1:0]         got_cell;
    cell_t [N-1:0]         exp_cell;
    logic                  fair_ok = 1'b1;
    int                    fair_in = 0;
    logic                  have_last0 = 1'b0;
    port_t                 last0_src;
    int                    last0_t = 0;
    logic                  drain_check = 1'b0;
    logic                  cons_check = 1'b0;
    int                    cyc = 0;
    int                    pending = 0;
    int                    sent_cnt = 0;
    int                    deliv_cnt = 0;
    int                    drop_cnt = 0;
    int                    drop_start = 0;
    int                    err_cnt = 0;
    int                    err_start = 0;
    int                    test_id = 0;
    int                    n_pass = 0;
    int                    n_fail = 0;
    int                    seed = 65003;
    logic [`DATA_WIDTH-1:0] data_cnt = '0;

    switch_top switch_top_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_cell   (in_cell),
        .out_valid (out_valid),
        .out_cell  (out_cell),
        .drop      (drop)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TOTAL_CELLS * 20 * CLK_PERIOD + 100 * CLK_PERIOD);
        $display("Timeout: the run did not finish within the expected time");
        $display("RESULT: FAIL");
        $finish;
    end

    // Remember what the ingress register takes in at this edge
    always @(posedge clk) begin
        sent_valid <= in_valid;
        sent_cell  <= in_cell;
    end

    // Scoreboard runs mid-cycle, where every DUT output is stable
    always @(negedge clk) begin
        cell_t c;
        int    k;
        cyc++;
        fair_ok = 1'b1;
        for (int i = 0; i < N; i++) begin
            if (sent_valid[i]) begin
                sent_cnt++;
                if (drop[i]) begin
                    drop_cnt++;
                end else begin
                    c.src  = port_t'(i);
                    c.dst  = sent_cell[i].dst;
                    c.data = sent_cell[i].data;
                    k = i * N + int'(c.dst);
                    exp_q[k].push_back(c);
                    exp_t[k].push_back(cyc);
                    pending++;
                end
            end
        end
        for (int o = 0; o < N; o++) begin
            chk_valid[o] = out_valid[o];
            got_cell[o]  = out_cell[o];
            exp_found[o] = 1'b0;
            if (out_valid[o]) begin
                deliv_cnt++;
                k = int'(out_cell[o].src) * N + o;
                if (exp_q[k].size() > 0) begin
                    exp_cell[o]  = exp_q[k].pop_front();
                    k            = exp_t[k].pop_front();
                    exp_found[o] = 1'b1;
                    pending--;
                end
                // A cell queued three cycles before the last grant was already requesting
                if (o == 0) begin
                    if (have_last0 && out_cell[0].src == last0_src) begin
                        for (int j = 0; j < N; j++) begin
                            if (j != int'(last0_src) && exp_t[j*N].size() > 0
                                && exp_t[j*N][0] <= last0_t - 3) begin
                                fair_ok = 1'b0;
                                fair_in = j;
                            end
                        end
                    end
                    have_last0 = 1'b1;
                    last0_src  = out_cell[0].src;
                    last0_t    = cyc;
                end
            end
        end
    end

    generate
        for (genvar o = 0; o < N; o++) begin : g_out_check
            a_cell_known: assert property (@(posedge clk) disable iff (!arst_n)
                chk_valid[o] |-> exp_found[o])
            else begin
                err_cnt++;
                $display("Output %0d delivered a cell that was never accepted (time %0t)",
                         o, $time);
            end
            a_cell_match: assert property (@(posedge clk) disable iff (!arst_n)
                (chk_valid[o] && exp_found[o]) |-> (got_cell[o] == exp_cell[o]))
            else begin
                err_cnt++;
                $display("ERROR %0t out_cell[%0d] expected %h got %h",
                         $time, o, exp_cell[o], got_cell[o]);
            end
            a_perm_src: assert property (@(posedge clk) disable iff (!arst_n)
                (test_id == 3 && out_valid[o]) |-> (out_cell[o].src == port_t'((o + N - 1) % N)))
            else begin
                err_cnt++;
                $display("ERROR %0t out_cell[%0d].src expected %0d got %0d", $time, o,
                         (o + N - 1) % N, $sampled(out_cell[o].src));
            end
        end
    endgenerate

    a_single_path: assert property (@(posedge clk) disable iff (!arst_n)
        (test_id == 1) |-> ((out_valid & 4'b1011) == '0))
    else begin
        err_cnt++;
        $display("ERROR %0t out_valid expected %b got %b", $time,
                 $sampled(out_valid) & 4'b0100, $sampled(out_valid));
    end

    // No buffer can fill during the first four tests
    a_no_drop: assert property (@(posedge clk) disable iff (!arst_n)
        (test_id >= 1 && test_id <= 4) |-> (drop == '0))
    else begin
        err_cnt++;
        $display("ERROR %0t drop expected %b got %b", $time, 4'b0000, $sampled(drop));
    end

    a_fair_rr: assert property (@(posedge clk) disable iff (!arst_n) fair_ok)
    else begin
        err_cnt++;
        $display("Output 0 served one input twice in a row while input %0d waited (time %0t)",
                 fair_in, $time);
    end

    a_drained: assert property (@(posedge clk) disable iff (!arst_n)
        drain_check |-> (pending == 0))
    else begin
        err_cnt++;
        $display("Cells still missing after the switch drained: %0d (time %0t)", pending, $time);
    end

    a_conserve: assert property (@(posedge clk) disable iff (!arst_n)
        cons_check |-> (sent_cnt == deliv_cnt + drop_cnt))
    else begin
        err_cnt++;
        $display("ERROR %0t sent_cnt expected %0d got %0d", $time, deliv_cnt + drop_cnt, sent_cnt);
    end

    a_drops_seen: assert property (@(posedge clk) disable iff (!arst_n)
        cons_check |-> (drop_cnt > drop_start))
    else begin
        err_cnt++;
        $display("No drop strobe appeared while the buffer was overloaded (time %0t)", $time);
    end

    task automatic drive_cycle(input port_vec_t v, input port_t [N-1:0] dst);
        @(negedge clk);
        for (int i = 0; i < N; i++) begin
            in_cell[i].dst  = dst[i];
            in_cell[i].data = data_cnt;
            if (v[i]) begin
                data_cnt++;
            end
        end
        in_valid = v;
    endtask

    task automatic drain_queues();
        int waited = 0;
        repeat (3) drive_cycle('0, '0);
        while (pending != 0 && waited < DRAIN_LIMIT) begin
            drive_cycle('0, '0);
            waited++;
        end
        repeat (2) drive_cycle('0, '0);
        drain_check = 1'b1;
        drive_cycle('0, '0);
        drain_check = 1'b0;
    endtask

    task automatic start_test(input int id);
        test_id   = id;
        err_start = err_cnt;
    endtask

    task automatic end_test(input string name);
        if (err_cnt == err_start) begin
            n_pass++;
            $display("Test %0d (%s): passed", test_id, name);
        end else begin
            n_fail++;
            $display("Test %0d (%s): failed with %0d errors", test_id, name, err_cnt - err_start);
        end
    endtask

    initial begin
        port_t [N-1:0] dst;
        port_vec_t     v;
        logic [31:0]   r;
        int            n;
        arst_n   = 1'b0;
        in_valid = '0;
        in_cell  = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        repeat (2) drive_cycle('0, '0);

        start_test(1);
        dst    = '0;
        dst[0] = port_t'(2);
        drive_cycle(4'b0001, dst);
        drain_queues();
        end_test("single path");

        start_test(2);
        dst[1] = port_t'(3);
        repeat (N_BURST) drive_cycle(4'b0010, dst);
        drain_queues();
        end_test("per-flow order");

        start_test(3);
        for (int i = 0; i < N; i++) begin
            dst[i] = port_t'((i + 1) % N);
        end
        repeat (N_PERM) drive_cycle('1, dst);
        drain_queues();
        end_test("parallel matching");

        start_test(4);
        dst = '0;
        repeat (N_CONT) drive_cycle('1, dst);
        drain_queues();
        end_test("contention and fairness");

        // Inputs 1 and 2 share output 3, so each buffer fills at half a cell per cycle
        start_test(5);
        dst        = '0;
        dst[1]     = port_t'(3);
        dst[2]     = port_t'(3);
        drop_start = drop_cnt;
        n          = 0;
        while (n < OVF_MAX && drop_cnt == drop_start) begin
            drive_cycle(4'b0110, dst);
            n++;
        end
        repeat (4) drive_cycle(4'b0110, dst);
        drain_queues();
        cons_check = 1'b1;
        drive_cycle('0, '0);
        cons_check = 1'b0;
        end_test("overflow and conservation");

        start_test(6);
        repeat (RAND_CYCLES) begin
            for (int i = 0; i < N; i++) begin
                r      = $random(seed);
                v[i]   = (r[2:0] < 3'd3);
                dst[i] = r[5:4];
            end
            drive_cycle(v, dst);
        end
        drain_queues();
        end_test("random traffic");

        $display("Tests passed: %0d, tests failed: %0d", n_pass, n_fail);
        if (n_fail == 0 && err_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
